/* hdl/decode_stage.sv */
////////////////////////////////////////////////////////////////////////////
// unknown instruction words decode to a bubble with no register write
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    input  logic                stall_i,
    input  mips_pkg::word_t     rd_data_a_i,
    input  mips_pkg::word_t     rd_data_b_i,
    input  mips_pkg::word_t     hi_i,
    input  mips_pkg::word_t     lo_i,
    input  mips_pkg::fwd_t      ex_fwd_i,
    input  mips_pkg::fwd_t      wb_fwd_i,
    output logic                inst_ready_o,
    output mips_pkg::reg_addr_t rd_addr_a_o,
    output mips_pkg::reg_addr_t rd_addr_b_o,
    dec_ex_if.src               dec_ex
);

    mips_pkg::word_t     inst_q;
    logic                inst_vld;
    mips_pkg::opcode_e   opcode;
    mips_pkg::funct_e    funct;
    mips_pkg::word_t     rs_val;
    mips_pkg::word_t     rt_val;
    mips_pkg::word_t     hi_val;
    mips_pkg::word_t     lo_val;
    mips_pkg::alu_op_e   op;
    mips_pkg::word_t     opnd_a;
    mips_pkg::word_t     opnd_b;
    mips_pkg::reg_addr_t dest;
    logic                write_en;
    mips_pkg::hilo_sel_e hilo_sel;

    // execute result wins over the one being written back
    function automatic mips_pkg::word_t fwd_reg(input mips_pkg::reg_addr_t addr,
                                                input mips_pkg::word_t     rf_val,
                                                input mips_pkg::fwd_t      ex_f,
                                                input mips_pkg::fwd_t      wb_f);
        if (addr == '0)
            return '0;
        if (ex_f.valid && ex_f.addr == addr)
            return ex_f.data;
        if (wb_f.valid && wb_f.addr == addr)
            return wb_f.data;
        return rf_val;
    endfunction

    // latch drains every unstalled cycle, so only the stall blocks it
    assign inst_ready_o = !stall_i;

    always_ff @(posedge clk) begin
        if (rst)
            inst_vld <= 1'b0;
        else if (!stall_i)
            inst_vld <= inst_valid_i;
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i && inst_ready_o)
            inst_q <= inst_i;
    end

    assign opcode      = mips_pkg::opcode_e'(inst_q[31:26]);
    assign funct       = mips_pkg::funct_e'(inst_q[5:0]);
    assign rd_addr_a_o = inst_q[25:21];
    assign rd_addr_b_o = inst_q[20:16];

    assign rs_val = fwd_reg(rd_addr_a_o, rd_data_a_i, ex_fwd_i, wb_fwd_i);
    assign rt_val = fwd_reg(rd_addr_b_o, rd_data_b_i, ex_fwd_i, wb_fwd_i);
    assign hi_val = mips_pkg::has_hi(ex_fwd_i.hilo_sel) ? ex_fwd_i.hi :
                    mips_pkg::has_hi(wb_fwd_i.hilo_sel) ? wb_fwd_i.hi : hi_i;
    assign lo_val = mips_pkg::has_lo(ex_fwd_i.hilo_sel) ? ex_fwd_i.lo :
                    mips_pkg::has_lo(wb_fwd_i.hilo_sel) ? wb_fwd_i.lo : lo_i;

    always_comb begin
        op       = mips_pkg::op_nop;
        opnd_a   = rs_val;
        opnd_b   = rt_val;
        dest     = inst_q[15:11];
        hilo_sel = mips_pkg::hilo_none;
        case (opcode)
            mips_pkg::opc_special: begin
                case (funct)
                    mips_pkg::fn_addu: op = mips_pkg::op_addu;
                    mips_pkg::fn_subu: op = mips_pkg::op_subu;
                    mips_pkg::fn_and:  op = mips_pkg::op_and;
                    mips_pkg::fn_or:   op = mips_pkg::op_or;
                    mips_pkg::fn_xor:  op = mips_pkg::op_xor;
                    mips_pkg::fn_nor:  op = mips_pkg::op_nor;
                    mips_pkg::fn_slt:  op = mips_pkg::op_slt;
                    mips_pkg::fn_sltu: op = mips_pkg::op_sltu;
                    mips_pkg::fn_sll:  op = mips_pkg::op_sll;
                    mips_pkg::fn_srl:  op = mips_pkg::op_srl;
                    mips_pkg::fn_sra:  op = mips_pkg::op_sra;
                    mips_pkg::fn_mfhi: op = mips_pkg::op_mfhi;
                    mips_pkg::fn_mflo: op = mips_pkg::op_mflo;
                    mips_pkg::fn_mthi: op = mips_pkg::op_mthi;
                    mips_pkg::fn_mtlo: op = mips_pkg::op_mtlo;
                    mips_pkg::fn_div:  op = mips_pkg::op_div;
                    mips_pkg::fn_divu: op = mips_pkg::op_divu;
                    default:           op = mips_pkg::op_nop;
                endcase
            end
            mips_pkg::opc_addiu: op = mips_pkg::op_addu;
            mips_pkg::opc_slti:  op = mips_pkg::op_slt;
            mips_pkg::opc_sltiu: op = mips_pkg::op_sltu;
            mips_pkg::opc_andi:  op = mips_pkg::op_and;
            mips_pkg::opc_ori:   op = mips_pkg::op_or;
            mips_pkg::opc_xori:  op = mips_pkg::op_xor;
            mips_pkg::opc_lui:   op = mips_pkg::op_lui;
            default:             op = mips_pkg::op_nop;
        endcase

        // immediate forms write rt, logical ones zero-extend
        if (opcode != mips_pkg::opc_special) begin
            dest = inst_q[20:16];
            if (opcode inside {mips_pkg::opc_andi, mips_pkg::opc_ori, mips_pkg::opc_xori})
                opnd_b = {16'h0, inst_q[15:0]};
            else
                opnd_b = {{16{inst_q[15]}}, inst_q[15:0]};
        end

        case (op)
            mips_pkg::op_mfhi: opnd_a = hi_val;
            mips_pkg::op_mflo: opnd_a = lo_val;
            mips_pkg::op_mthi: hilo_sel = mips_pkg::hilo_hi;
            mips_pkg::op_mtlo: hilo_sel = mips_pkg::hilo_lo;
            mips_pkg::op_div, mips_pkg::op_divu: hilo_sel = mips_pkg::hilo_both;
            default: ;
        endcase
        write_en = (op != mips_pkg::op_nop) && (hilo_sel == mips_pkg::hilo_none);
    end

    always_ff @(posedge clk) begin
        if (rst)
            dec_ex.valid <= 1'b0;
        else if (!stall_i)
            dec_ex.valid <= inst_vld;
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            dec_ex.op        <= op;
            dec_ex.operand_a <= opnd_a;
            dec_ex.operand_b <= opnd_b;
            dec_ex.shamt     <= inst_q[10:6];
            dec_ex.dest      <= dest;
            dec_ex.write_en  <= write_en;
            dec_ex.hilo_sel  <= hilo_sel;
        end
    end

endmodule

/* hdl/divider.sv */
////////////////////////////////////////////////////////////////////////////
// done follows start by DIV_STEPS+1 cycles, divisor must be nonzero
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module divider (
    input  logic            clk,
    input  logic            rst,
    input  logic            start_i,
    input  logic            signed_i,
    input  mips_pkg::word_t dividend_i,
    input  mips_pkg::word_t divisor_i,
    output logic            done_o,
    output mips_pkg::word_t quotient_o,
    output mips_pkg::word_t remainder_o
);

    localparam int CNT_W = $clog2(mips_pkg::DIV_STEPS + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    mips_pkg::word_t  quo_q;
    mips_pkg::word_t  rem_q;
    mips_pkg::word_t  dvs_q;
    logic             neg_quo;
    logic             neg_rem;
    logic [33:0]      trial;

    // shift in the next dividend bit and try the subtraction
    assign trial = {1'b0, rem_q, quo_q[31]} - {2'b00, dvs_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            done_o <= 1'b0;
            count  <= '0;
        end else begin
            done_o <= busy && (count == CNT_W'(mips_pkg::DIV_STEPS - 1));
            if (start_i) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CNT_W'(mips_pkg::DIV_STEPS - 1))
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q   <= (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
            dvs_q   <= (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;
            rem_q   <= '0;
            neg_quo <= signed_i && (dividend_i[31] ^ divisor_i[31]);
            neg_rem <= signed_i && dividend_i[31];
        end else if (busy) begin
            if (!trial[33]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= {rem_q[30:0], quo_q[31]};
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // remainder keeps the dividend's sign
    assign quotient_o  = neg_quo ? -quo_q : quo_q;
    assign remainder_o = neg_rem ? -rem_q : rem_q;

endmodule

/* hdl/execute_stage.sv */
////////////////////////////////////////////////////////////////////////////
// a divide stays in the input bundle, with stall high, until the done pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            div_done_i,
    input  mips_pkg::word_t quotient_i,
    input  mips_pkg::word_t remainder_i,
    output logic            stall_o,
    output logic            div_start_o,
    output logic            div_signed_o,
    output mips_pkg::word_t dividend_o,
    output mips_pkg::word_t divisor_o,
    output mips_pkg::fwd_t  ex_fwd_o,
    dec_ex_if.dst           dec_ex,
    ex_wb_if.src            ex_wb
);

    logic            is_div;
    logic            div_pending;
    logic            fire;
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    mips_pkg::word_t result;
    mips_pkg::word_t hi_val;
    mips_pkg::word_t lo_val;

    assign a      = dec_ex.operand_a;
    assign b      = dec_ex.operand_b;
    assign is_div = dec_ex.valid &&
                    (dec_ex.op == mips_pkg::op_div || dec_ex.op == mips_pkg::op_divu);

    assign stall_o      = is_div && !div_done_i;
    assign div_start_o  = is_div && !div_pending;
    assign div_signed_o = (dec_ex.op == mips_pkg::op_div);
    assign dividend_o   = a;
    assign divisor_o    = b;
    assign fire         = dec_ex.valid && !stall_o;

    always_ff @(posedge clk) begin
        if (rst)
            div_pending <= 1'b0;
        else if (div_done_i)
            div_pending <= 1'b0;
        else if (div_start_o)
            div_pending <= 1'b1;
    end

    always_comb begin
        case (dec_ex.op)
            mips_pkg::op_addu: result = a + b;
            mips_pkg::op_subu: result = a - b;
            mips_pkg::op_and:  result = a & b;
            mips_pkg::op_or:   result = a | b;
            mips_pkg::op_xor:  result = a ^ b;
            mips_pkg::op_nor:  result = ~(a | b);
            mips_pkg::op_slt:  result = {31'h0, $signed(a) < $signed(b)};
            mips_pkg::op_sltu: result = {31'h0, a < b};
            mips_pkg::op_sll:  result = b << dec_ex.shamt;
            mips_pkg::op_srl:  result = b >> dec_ex.shamt;
            mips_pkg::op_sra:  result = $signed(b) >>> dec_ex.shamt;
            mips_pkg::op_lui:  result = {b[15:0], 16'h0};
            mips_pkg::op_mfhi, mips_pkg::op_mflo: result = a;
            default:           result = '0;
        endcase
    end

    // divide writes quotient to lo, remainder to hi
    assign hi_val = is_div ? remainder_i : a;
    assign lo_val = is_div ? quotient_i : a;

    assign ex_fwd_o.valid    = fire && dec_ex.write_en;
    assign ex_fwd_o.addr     = dec_ex.dest;
    assign ex_fwd_o.data     = result;
    assign ex_fwd_o.hi       = hi_val;
    assign ex_fwd_o.lo       = lo_val;
    assign ex_fwd_o.hilo_sel = fire ? dec_ex.hilo_sel : mips_pkg::hilo_none;

    always_ff @(posedge clk) begin
        if (rst)
            ex_wb.valid <= 1'b0;
        else
            ex_wb.valid <= fire;
    end

    always_ff @(posedge clk) begin
        ex_wb.dest     <= dec_ex.dest;
        ex_wb.write_en <= dec_ex.write_en;
        ex_wb.result   <= result;
        ex_wb.hi       <= hi_val;
        ex_wb.lo       <= lo_val;
        ex_wb.hilo_sel <= dec_ex.hilo_sel;
    end

endmodule

/* hdl/mips_core.sv */
////////////////////////////////////////////////////////////////////////////
// results appear three edges after acceptance, no back-pressure on output
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mips_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    output logic                inst_ready_o,
    output logic                wb_valid_o,
    output mips_pkg::reg_addr_t wb_addr_o,
    output mips_pkg::word_t     wb_data_o
);

    logic                stall;
    mips_pkg::reg_addr_t rd_addr_a;
    mips_pkg::reg_addr_t rd_addr_b;
    mips_pkg::word_t     rd_data_a;
    mips_pkg::word_t     rd_data_b;
    mips_pkg::word_t     hi;
    mips_pkg::word_t     lo;
    mips_pkg::fwd_t      ex_fwd;
    mips_pkg::fwd_t      wb_fwd;
    logic                div_start;
    logic                div_signed;
    logic                div_done;
    mips_pkg::word_t     dividend;
    mips_pkg::word_t     divisor;
    mips_pkg::word_t     quotient;
    mips_pkg::word_t     remainder;
    logic                rf_wr_en;
    mips_pkg::reg_addr_t rf_wr_addr;
    mips_pkg::word_t     rf_wr_data;

    dec_ex_if dec_ex ();
    ex_wb_if  ex_wb ();

    decode_stage u_decode (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i), .stall_i(stall),
        .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b), .hi_i(hi), .lo_i(lo),
        .ex_fwd_i(ex_fwd), .wb_fwd_i(wb_fwd),
        .inst_ready_o(inst_ready_o), .rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b),
        .dec_ex(dec_ex.src)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst),
        .rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
        .wr_en_i(rf_wr_en), .wr_addr_i(rf_wr_addr), .wr_data_i(rf_wr_data),
        .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst),
        .div_done_i(div_done), .quotient_i(quotient), .remainder_i(remainder),
        .stall_o(stall), .div_start_o(div_start), .div_signed_o(div_signed),
        .dividend_o(dividend), .divisor_o(divisor), .ex_fwd_o(ex_fwd),
        .dec_ex(dec_ex.dst), .ex_wb(ex_wb.src)
    );

    divider u_divider (
        .clk(clk), .rst(rst),
        .start_i(div_start), .signed_i(div_signed),
        .dividend_i(dividend), .divisor_i(divisor),
        .done_o(div_done), .quotient_o(quotient), .remainder_o(remainder)
    );

    writeback_stage u_writeback (
        .clk(clk), .rst(rst), .ex_wb(ex_wb.dst),
        .rf_wr_en_o(rf_wr_en), .rf_wr_addr_o(rf_wr_addr), .rf_wr_data_o(rf_wr_data),
        .hi_o(hi), .lo_o(lo), .wb_fwd_o(wb_fwd),
        .wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
    );

endmodule

/* hdl/mips_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// field codes follow the MIPS32 encoding, only the decoded subset is listed
// overflow traps and division by zero are outside what the core handles
////////////////////////////////////////////////////////////////////////////
package mips_pkg;

    localparam int NUM_REGS  = 32;
    localparam int DIV_STEPS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [4:0] {
        op_nop, op_addu, op_subu, op_and, op_or, op_xor, op_nor, op_slt, op_sltu,
        op_sll, op_srl, op_sra, op_lui,
        op_mfhi, op_mflo, op_mthi, op_mtlo,
        op_div, op_divu
    } alu_op_e;

    typedef enum logic [5:0] {
        opc_special = 6'h00, opc_addiu = 6'h09, opc_slti = 6'h0a, opc_sltiu = 6'h0b,
        opc_andi    = 6'h0c, opc_ori   = 6'h0d, opc_xori = 6'h0e, opc_lui   = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03,
        fn_mfhi = 6'h10, fn_mthi = 6'h11, fn_mflo = 6'h12, fn_mtlo = 6'h13,
        fn_div  = 6'h1a, fn_divu = 6'h1b,
        fn_addu = 6'h21, fn_subu = 6'h23, fn_and  = 6'h24, fn_or   = 6'h25,
        fn_xor  = 6'h26, fn_nor  = 6'h27, fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [1:0] {
        hilo_none, hilo_hi, hilo_lo, hilo_both
    } hilo_sel_e;

    // one forwarding source, gpr result plus hi/lo values
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
        word_t     hi;
        word_t     lo;
        hilo_sel_e hilo_sel;
    } fwd_t;

    function automatic logic has_hi(input hilo_sel_e sel);
        return (sel == hilo_hi) || (sel == hilo_both);
    endfunction

    function automatic logic has_lo(input hilo_sel_e sel);
        return (sel == hilo_lo) || (sel == hilo_both);
    endfunction

endpackage

/* hdl/pipe_ifs.sv */
////////////////////////////////////////////////////////////////////////////
// stage-to-stage bundles, all signals registered by the driving stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface dec_ex_if;
    logic                valid;
    mips_pkg::alu_op_e   op;
    mips_pkg::word_t     operand_a;
    mips_pkg::word_t     operand_b;
    logic [4:0]          shamt;
    mips_pkg::reg_addr_t dest;
    logic                write_en;
    mips_pkg::hilo_sel_e hilo_sel;

    modport src (output valid, op, operand_a, operand_b, shamt, dest, write_en, hilo_sel);
    modport dst (input  valid, op, operand_a, operand_b, shamt, dest, write_en, hilo_sel);
endinterface

interface ex_wb_if;
    logic                valid;
    mips_pkg::reg_addr_t dest;
    logic                write_en;
    mips_pkg::word_t     result;
    mips_pkg::word_t     hi;
    mips_pkg::word_t     lo;
    mips_pkg::hilo_sel_e hilo_sel;

    modport src (output valid, dest, write_en, result, hi, lo, hilo_sel);
    modport dst (input  valid, dest, write_en, result, hi, lo, hilo_sel);
endinterface

/* hdl/reg_file.sv */
////////////////////////////////////////////////////////////////////////////
// entries other than r0 hold no value until first written
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t rd_addr_a_i,
    input  mips_pkg::reg_addr_t rd_addr_b_i,
    input  logic                wr_en_i,
    input  mips_pkg::reg_addr_t wr_addr_i,
    input  mips_pkg::word_t     wr_data_i,
    output mips_pkg::word_t     rd_data_a_o,
    output mips_pkg::word_t     rd_data_b_o
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];

    // no writes while the core is held in reset
    always_ff @(posedge clk) begin
        if (wr_en_i && !rst)
            regs[wr_addr_i] <= wr_data_i;
    end

    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

endmodule

/* hdl/writeback_stage.sv */
////////////////////////////////////////////////////////////////////////////
// writes to r0 reach neither the register file nor the writeback port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module writeback_stage (
    input  logic                clk,
    input  logic                rst,
    ex_wb_if.dst                ex_wb,
    output logic                rf_wr_en_o,
    output mips_pkg::reg_addr_t rf_wr_addr_o,
    output mips_pkg::word_t     rf_wr_data_o,
    output mips_pkg::word_t     hi_o,
    output mips_pkg::word_t     lo_o,
    output mips_pkg::fwd_t      wb_fwd_o,
    output logic                wb_valid_o,
    output mips_pkg::reg_addr_t wb_addr_o,
    output mips_pkg::word_t     wb_data_o
);

    assign rf_wr_en_o   = ex_wb.valid && ex_wb.write_en && (ex_wb.dest != '0);
    assign rf_wr_addr_o = ex_wb.dest;
    assign rf_wr_data_o = ex_wb.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (ex_wb.valid) begin
            if (mips_pkg::has_hi(ex_wb.hilo_sel))
                hi_o <= ex_wb.hi;
            if (mips_pkg::has_lo(ex_wb.hilo_sel))
                lo_o <= ex_wb.lo;
        end
    end

    assign wb_fwd_o.valid    = rf_wr_en_o;
    assign wb_fwd_o.addr     = ex_wb.dest;
    assign wb_fwd_o.data     = ex_wb.result;
    assign wb_fwd_o.hi       = ex_wb.hi;
    assign wb_fwd_o.lo       = ex_wb.lo;
    assign wb_fwd_o.hilo_sel = ex_wb.valid ? ex_wb.hilo_sel : mips_pkg::hilo_none;

    always_ff @(posedge clk) begin
        if (rst)
            wb_valid_o <= 1'b0;
        else
            wb_valid_o <= rf_wr_en_o;
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= ex_wb.dest;
        wb_data_o <= ex_wb.result;
    end

endmodule

/* mips_core.f */
hdl/mips_pkg.sv
hdl/pipe_ifs.sv
hdl/reg_file.sv
hdl/divider.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/mips_core.sv
tb/tb_clock_gen.sv
tb/mips_core_tb.sv

/* tb/mips_core_tb.sv */
////////////////////////////////////////////////////////////////////////////
// expected results are hand computed, table registers are written before read
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mips_core_tb;

    typedef struct packed {
        mips_pkg::word_t     inst;
        logic                has_wb;
        mips_pkg::reg_addr_t dest;
        mips_pkg::word_t     value;
        logic                is_div;
    } entry_t;

    logic                clk;
    logic                rst;
    logic                inst_valid;
    mips_pkg::word_t     inst;
    logic                inst_ready;
    logic                wb_valid;
    mips_pkg::reg_addr_t wb_addr;
    mips_pkg::word_t     wb_data;

    entry_t entries[$];
    string  names[$];
    int     exp_idx_q[$];
    int     wb_idx;
    int     cycle_count = 0;
    int     timeout_limit = 0;
    logic [31:0] lfsr;
    logic [1:0]  gap;
    logic        ready_low;
    logic        ready_at_edge;

    tb_clock_gen clock_gen (.clk_o(clk), .rst_o(rst));

    mips_core dut (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid), .inst_i(inst), .inst_ready_o(inst_ready),
        .wb_valid_o(wb_valid), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
    endtask

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic mips_pkg::word_t r_op(input mips_pkg::funct_e fn, input int rd,
                                             input int rs, input int rt, input int sa);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic mips_pkg::word_t i_op(input mips_pkg::opcode_e opc, input int rt,
                                             input int rs, input logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_wb(input string name, input mips_pkg::word_t word, input int dest,
                          input mips_pkg::word_t value);
        entry_t e;
        e.inst   = word;
        e.has_wb = 1'b1;
        e.dest   = 5'(dest);
        e.value  = value;
        e.is_div = 1'b0;
        entries.push_back(e);
        names.push_back(name);
        exp_idx_q.push_back(entries.size() - 1);
    endtask

    task automatic add_nowb(input string name, input mips_pkg::word_t word,
                            input logic is_div);
        entry_t e;
        e.inst   = word;
        e.has_wb = 1'b0;
        e.dest   = '0;
        e.value  = '0;
        e.is_div = is_div;
        entries.push_back(e);
        names.push_back(name);
    endtask

    task automatic build_table();
        add_wb("addiu r1", i_op(mips_pkg::opc_addiu, 1, 0, 16'h0005), 1, 32'h5);
        add_wb("addiu r2", i_op(mips_pkg::opc_addiu, 2, 0, 16'hfffd), 2, 32'hfffffffd);
        add_wb("addu", r_op(mips_pkg::fn_addu, 3, 1, 2, 0), 3, 32'h2);
        add_wb("subu", r_op(mips_pkg::fn_subu, 4, 1, 2, 0), 4, 32'h8);
        add_wb("and", r_op(mips_pkg::fn_and, 5, 1, 2, 0), 5, 32'h5);
        add_wb("or", r_op(mips_pkg::fn_or, 6, 1, 2, 0), 6, 32'hfffffffd);
        add_wb("xor", r_op(mips_pkg::fn_xor, 7, 1, 2, 0), 7, 32'hfffffff8);
        add_wb("nor", r_op(mips_pkg::fn_nor, 8, 1, 2, 0), 8, 32'h2);
        add_wb("slt", r_op(mips_pkg::fn_slt, 9, 2, 1, 0), 9, 32'h1);
        add_wb("sltu", r_op(mips_pkg::fn_sltu, 10, 2, 1, 0), 10, 32'h0);
        add_wb("lui", i_op(mips_pkg::opc_lui, 11, 0, 16'h1234), 11, 32'h12340000);
        add_wb("ori", i_op(mips_pkg::opc_ori, 11, 11, 16'h8765), 11, 32'h12348765);
        add_wb("andi", i_op(mips_pkg::opc_andi, 12, 11, 16'hff00), 12, 32'h00008700);
        add_wb("xori", i_op(mips_pkg::opc_xori, 13, 11, 16'hffff), 13, 32'h1234789a);
        add_wb("slti", i_op(mips_pkg::opc_slti, 14, 2, 16'hfffe), 14, 32'h1);
        add_wb("sltiu", i_op(mips_pkg::opc_sltiu, 15, 1, 16'hfffe), 15, 32'h1);
        add_wb("sll", r_op(mips_pkg::fn_sll, 16, 0, 11, 4), 16, 32'h23487650);
        add_wb("srl", r_op(mips_pkg::fn_srl, 17, 0, 2, 8), 17, 32'h00ffffff);
        add_wb("sra", r_op(mips_pkg::fn_sra, 18, 0, 2, 1), 18, 32'hfffffffe);
        // dependent chain on r19
        add_wb("chain start", i_op(mips_pkg::opc_addiu, 19, 0, 16'h0001), 19, 32'h1);
        add_wb("chain double 1", r_op(mips_pkg::fn_addu, 19, 19, 19, 0), 19, 32'h2);
        add_wb("chain double 2", r_op(mips_pkg::fn_addu, 19, 19, 19, 0), 19, 32'h4);
        add_wb("chain add", r_op(mips_pkg::fn_addu, 20, 19, 1, 0), 20, 32'h9);
        add_wb("chain sub", r_op(mips_pkg::fn_subu, 21, 20, 19, 0), 21, 32'h5);
        add_wb("addiu r22", i_op(mips_pkg::opc_addiu, 22, 0, 16'hfff9), 22, 32'hfffffff9);
        add_wb("addiu r23", i_op(mips_pkg::opc_addiu, 23, 0, 16'h0002), 23, 32'h2);
        // -7 / 2 gives -3 remainder -1
        add_nowb("div -7/2", r_op(mips_pkg::fn_div, 0, 22, 23, 0), 1'b1);
        add_wb("div -7/2 quotient", r_op(mips_pkg::fn_mflo, 24, 0, 0, 0), 24, 32'hfffffffd);
        add_wb("div -7/2 remainder", r_op(mips_pkg::fn_mfhi, 25, 0, 0, 0), 25, 32'hffffffff);
        add_nowb("divu", r_op(mips_pkg::fn_divu, 0, 22, 23, 0), 1'b1);
        add_wb("divu remainder", r_op(mips_pkg::fn_mfhi, 26, 0, 0, 0), 26, 32'h1);
        add_wb("divu quotient", r_op(mips_pkg::fn_mflo, 27, 0, 0, 0), 27, 32'h7ffffffc);
        // 5 / -3 gives -1 remainder 2
        add_nowb("div 5/-3", r_op(mips_pkg::fn_div, 0, 1, 2, 0), 1'b1);
        add_wb("div 5/-3 quotient", r_op(mips_pkg::fn_mflo, 28, 0, 0, 0), 28, 32'hffffffff);
        add_wb("div 5/-3 remainder", r_op(mips_pkg::fn_mfhi, 29, 0, 0, 0), 29, 32'h2);
        add_nowb("mthi", r_op(mips_pkg::fn_mthi, 0, 4, 0, 0), 1'b0);
        add_wb("mfhi after mthi", r_op(mips_pkg::fn_mfhi, 30, 0, 0, 0), 30, 32'h8);
        add_nowb("mtlo", r_op(mips_pkg::fn_mtlo, 0, 5, 0, 0), 1'b0);
        add_wb("mflo after mtlo", r_op(mips_pkg::fn_mflo, 31, 0, 0, 0), 31, 32'h5);
        add_nowb("addiu to r0", i_op(mips_pkg::opc_addiu, 0, 1, 16'h0007), 1'b0);
        add_nowb("addu to r0", r_op(mips_pkg::fn_addu, 0, 1, 1, 0), 1'b0);
        add_wb("read r0", r_op(mips_pkg::fn_addu, 3, 0, 0, 0), 3, 32'h0);
    endtask

    // ready only changes on rising edges, so the falling edge sees the value in use
    task automatic next_cycle();
        @(negedge clk);
        ready_at_edge = inst_ready;
        if (!inst_ready)
            ready_low = 1'b1;
        @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check("wb_valid_o during reset", 32'h0, wb_valid);
        end else if (wb_valid) begin
            if (exp_idx_q.size() == 0)
                abort_run("writeback event seen with no instruction left that writes a register");
            wb_idx = exp_idx_q.pop_front();
            check({names[wb_idx], " address"}, entries[wb_idx].dest, wb_addr);
            check({names[wb_idx], " data"}, entries[wb_idx].value, wb_data);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit)
            abort_run($sformatf("timeout: core made no progress within %0d cycles", cycle_count));
    end

    initial begin
        inst_valid = 1'b0;
        inst = '0;
        lfsr = 32'hcc59;
        ready_low = 1'b0;
        ready_at_edge = 1'b0;
        build_table();
        timeout_limit = entries.size() * (mips_pkg::DIV_STEPS + 8) + 16;

        do
            @(negedge clk);
        while (rst);
        check("wb_valid_o after reset", 32'h0, wb_valid);
        check("inst_ready_o after reset", 32'h1, inst_ready);
        @(posedge clk);

        for (int i = 0; i < entries.size(); i++) begin
            lfsr = lfsr_next(lfsr);
            gap[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            gap[1] = lfsr[0];
            if (gap != 2'd0) begin
                inst_valid <= 1'b0;
                repeat (gap) next_cycle();
            end
            inst_valid <= 1'b1;
            inst <= entries[i].inst;
            do
                next_cycle();
            while (!ready_at_edge);
            // the word after a divide can be latched before the stall rises
            if (i > 1 && entries[i-2].is_div && !ready_low)
                abort_run($sformatf("inst_ready_o stayed high while %s ran", names[i-2]));
            if (entries[i].is_div)
                ready_low = 1'b0;
        end
        inst_valid <= 1'b0;

        // drain, then give a stray event time to show up
        while (exp_idx_q.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// 10 ns clock, reset held high for the first 16 rising edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // released on a rising edge, like any other registered signal
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule
